// File: hw/rf_pkg.sv
package rf_pkg;

    // Line address into the register file
    localparam int RF_ADDR_W = 8;

    // One register-file line in bits
    localparam int RF_DATA_W = 256;

    // Line count of a move, load or store command
    // A count of zero is never issued
    localparam int LINE_CNT_W = 8;

    // Engine that currently owns the RAM port
    typedef enum logic {
        OP_MV,
        OP_LDST
    } rf_op_t;

endpackage

// File: hw/sdram_pkg.sv
package sdram_pkg;

    // Avalon word address
    localparam int SDRAM_ADDR_W = 32;

    // Avalon data bus
    localparam int SDRAM_DATA_W = 64;

    // SDRAM words per register-file line (256 / 64)
    localparam int BEATS_PER_LINE = 4;

endpackage

// File: hw/rf_ram.sv
`timescale 1ns/1ns

module rf_ram
    import rf_pkg::*;
#(
    parameter int ADDR_W = RF_ADDR_W,
    parameter int DATA_W = RF_DATA_W
) (
    input  logic                clk,

    input  logic [ADDR_W-1 : 0] addr,
    input  logic [DATA_W-1 : 0] d,
    input  logic                we,
    input  logic                re,
    output logic [DATA_W-1 : 0] q
);

localparam int DEPTH = 1 << ADDR_W;

logic [DATA_W-1 : 0] mem [0 : DEPTH-1];

// Single port, one line per access
always_ff @(posedge clk) begin
    if (we) begin
        mem[addr] <= d;
    end
    // q keeps the last line read until the next read
    if (re) begin
        q <= mem[addr];
    end
end

endmodule

// File: hw/rf_mv.sv
`timescale 1ns/1ns

module rf_mv
    import rf_pkg::*;
#(
    parameter int ADDR_W = RF_ADDR_W,
    parameter int DATA_W = RF_DATA_W
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    start,
    input  logic [ADDR_W-1 : 0]     src_addr,
    input  logic [ADDR_W-1 : 0]     dst_addr,
    input  logic [LINE_CNT_W-1 : 0] line_num,

    output logic [ADDR_W-1 : 0]     ram_addr,
    output logic [DATA_W-1 : 0]     ram_d,
    output logic                    ram_we,
    output logic                    ram_re,
    input  logic [DATA_W-1 : 0]     ram_q,

    output logic                    done
);

logic                    active;
logic                    wr_phase;
logic [ADDR_W-1 : 0]     src_ptr;
logic [ADDR_W-1 : 0]     dst_ptr;
logic [LINE_CNT_W-1 : 0] lines_left;

// Control: read a source line, then write it to the destination
always_ff @(posedge clk) begin
    if (rst) begin
        active   <= 1'b0;
        wr_phase <= 1'b0;
        done     <= 1'b0;
    end else begin
        done <= 1'b0;
        if (start) begin
            active   <= 1'b1;
            wr_phase <= 1'b0;
        end else if (active) begin
            wr_phase <= ~wr_phase;
            // Last write goes out this cycle
            if (wr_phase && lines_left == LINE_CNT_W'(1)) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end
end

// Address counters, ascending so a downward overlap copies correctly
always_ff @(posedge clk) begin
    if (start) begin
        src_ptr    <= src_addr;
        dst_ptr    <= dst_addr;
        lines_left <= line_num;
    end else if (active) begin
        if (wr_phase) begin
            dst_ptr    <= dst_ptr + 1'b1;
            lines_left <= lines_left - 1'b1;
        end else begin
            src_ptr <= src_ptr + 1'b1;
        end
    end
end

assign ram_re = active && !wr_phase;
assign ram_we = active && wr_phase;

// Read address wins the port whenever a read is pending
assign ram_addr = ram_re ? src_ptr : dst_ptr;

// Line read in the previous cycle goes straight back in
assign ram_d = ram_q;

endmodule

// File: hw/rf_ldst.sv
`timescale 1ns/1ns

module rf_ldst
    import rf_pkg::*;
    import sdram_pkg::*;
#(
    parameter int ADDR_W       = RF_ADDR_W,
    parameter int DATA_W       = RF_DATA_W,
    parameter int SDRAM_ADDR_W = sdram_pkg::SDRAM_ADDR_W,
    parameter int SDRAM_DATA_W = sdram_pkg::SDRAM_DATA_W
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      load_start,
    input  logic                      store_start,
    input  logic [ADDR_W-1 : 0]       rf_addr_base,
    input  logic [SDRAM_ADDR_W-1 : 0] sdram_addr_base,
    input  logic [LINE_CNT_W-1 : 0]   line_num,

    output logic [ADDR_W-1 : 0]       ram_addr,
    output logic [DATA_W-1 : 0]       ram_d,
    output logic                      ram_we,
    output logic                      ram_re,
    input  logic [DATA_W-1 : 0]       ram_q,

    output logic [SDRAM_ADDR_W-1 : 0] avs_address,
    output logic                      avs_read,
    output logic                      avs_write,
    output logic [SDRAM_DATA_W-1 : 0] avs_writedata,
    input  logic [SDRAM_DATA_W-1 : 0] avs_readdata,
    input  logic                      avs_readdatavalid,
    input  logic                      avs_waitrequest,

    output logic                      done
);

localparam int BEAT_W = $clog2(BEATS_PER_LINE) + 1;
localparam logic [BEAT_W-1 : 0] ALL_BEATS = BEAT_W'(BEATS_PER_LINE);
localparam logic [BEAT_W-1 : 0] LAST_BEAT = BEAT_W'(BEATS_PER_LINE - 1);

typedef enum logic [2:0] {
    S_IDLE,
    S_LD_RD,
    S_LD_WR,
    S_ST_RD,
    S_ST_LATCH,
    S_ST_WR
} state_t;

state_t state;

logic [BEAT_W-1 : 0]       req_cnt;
logic [BEAT_W-1 : 0]       rcv_cnt;
logic [SDRAM_ADDR_W-1 : 0] sd_addr;
logic [ADDR_W-1 : 0]       rf_ptr;
logic [LINE_CNT_W-1 : 0]   lines_left;
logic [DATA_W-1 : 0]       line_buf;

logic rd_acc;
logic wr_acc;
logic last_line;
logic line_stored;

assign rd_acc      = avs_read && !avs_waitrequest;
assign wr_acc      = avs_write && !avs_waitrequest;
assign last_line   = (lines_left == LINE_CNT_W'(1));
assign line_stored = wr_acc && (req_cnt == LAST_BEAT);

always_ff @(posedge clk) begin
    if (rst) begin
        state   <= S_IDLE;
        done    <= 1'b0;
        req_cnt <= '0;
        rcv_cnt <= '0;
    end else begin
        done <= 1'b0;
        case (state)
            S_IDLE: begin
                req_cnt <= '0;
                rcv_cnt <= '0;
                if (load_start) begin
                    state <= S_LD_RD;
                end else if (store_start) begin
                    state <= S_ST_RD;
                end
            end
            S_LD_RD: begin
                if (rd_acc) begin
                    req_cnt <= req_cnt + 1'b1;
                end
                // Fourth returned word completes the line
                if (avs_readdatavalid) begin
                    rcv_cnt <= rcv_cnt + 1'b1;
                    if (rcv_cnt == LAST_BEAT) begin
                        state <= S_LD_WR;
                    end
                end
            end
            S_LD_WR: begin
                req_cnt <= '0;
                rcv_cnt <= '0;
                state   <= last_line ? S_IDLE : S_LD_RD;
                done    <= last_line;
            end
            S_ST_RD: begin
                state <= S_ST_LATCH;
            end
            S_ST_LATCH: begin
                req_cnt <= '0;
                state   <= S_ST_WR;
            end
            S_ST_WR: begin
                if (wr_acc) begin
                    req_cnt <= req_cnt + 1'b1;
                end
                if (line_stored) begin
                    state <= last_line ? S_IDLE : S_ST_RD;
                    done  <= last_line;
                end
            end
            default: begin
                state <= S_IDLE;
            end
        endcase
    end
end

// Addresses, line count and the line shift register
always_ff @(posedge clk) begin
    if (state == S_IDLE && (load_start || store_start)) begin
        rf_ptr     <= rf_addr_base;
        sd_addr    <= sdram_addr_base;
        lines_left <= line_num;
    end else begin
        if (rd_acc || wr_acc) begin
            sd_addr <= sd_addr + 1'b1;
        end
        if (state == S_LD_WR || line_stored) begin
            rf_ptr     <= rf_ptr + 1'b1;
            lines_left <= lines_left - 1'b1;
        end
    end

    // Low word arrives first and ends up at the bottom
    if (state == S_LD_RD && avs_readdatavalid) begin
        line_buf <= {avs_readdata, line_buf[DATA_W-1 : SDRAM_DATA_W]};
    end else if (state == S_ST_LATCH) begin
        line_buf <= ram_q;
    end else if (wr_acc) begin
        line_buf <= line_buf >> SDRAM_DATA_W;
    end
end

assign ram_addr = rf_ptr;
assign ram_d    = line_buf;
assign ram_we   = (state == S_LD_WR);
assign ram_re   = (state == S_ST_RD);

// Request stays up with the same address until waitrequest drops
assign avs_address   = sd_addr;
assign avs_read      = (state == S_LD_RD) && (req_cnt != ALL_BEATS);
assign avs_write     = (state == S_ST_WR);
assign avs_writedata = line_buf[SDRAM_DATA_W-1 : 0];

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ns

module register_file
    import rf_pkg::*;
    import sdram_pkg::*;
#(
    parameter int ADDR_W       = RF_ADDR_W,
    parameter int DATA_W       = RF_DATA_W,
    parameter int SDRAM_ADDR_W = sdram_pkg::SDRAM_ADDR_W,
    parameter int SDRAM_DATA_W = sdram_pkg::SDRAM_DATA_W
) (
    input  logic                      clk,
    input  logic                      rst,

    // Control unit
    input  logic                      move_start,
    input  logic [ADDR_W-1 : 0]       move_src_addr,
    input  logic [ADDR_W-1 : 0]       move_dst_addr,
    input  logic [LINE_CNT_W-1 : 0]   move_line_num,
    output logic                      move_done,

    input  logic                      load_start,
    input  logic                      store_start,
    input  logic [ADDR_W-1 : 0]       ldst_rf_addr,
    input  logic [SDRAM_ADDR_W-1 : 0] ldst_sdram_addr,
    input  logic [LINE_CNT_W-1 : 0]   ldst_line_num,
    output logic                      ldst_done,

    output logic                      busy,

    // Avalon master
    output logic [SDRAM_ADDR_W-1 : 0] avs_address,
    output logic                      avs_read,
    output logic                      avs_write,
    output logic [SDRAM_DATA_W-1 : 0] avs_writedata,
    input  logic [SDRAM_DATA_W-1 : 0] avs_readdata,
    input  logic                      avs_readdatavalid,
    input  logic                      avs_waitrequest
);

rf_op_t operation;

logic mv_go;
logic ld_go;
logic st_go;

logic [ADDR_W-1 : 0] rf_addr;
logic [DATA_W-1 : 0] rf_d;
logic [DATA_W-1 : 0] rf_q;
logic                rf_we;
logic                rf_re;

logic [ADDR_W-1 : 0] mv_addr;
logic [DATA_W-1 : 0] mv_d;
logic                mv_we;
logic                mv_re;

logic [ADDR_W-1 : 0] ldst_addr;
logic [DATA_W-1 : 0] ldst_d;
logic                ldst_we;
logic                ldst_re;

// Starts while busy never reach the engines
assign mv_go = move_start && !busy;
assign ld_go = load_start && !busy;
assign st_go = store_start && !busy;

always_ff @(posedge clk) begin
    if (rst) begin
        busy      <= 1'b0;
        operation <= OP_MV;
    end else if (mv_go) begin
        busy      <= 1'b1;
        operation <= OP_MV;
    end else if (ld_go || st_go) begin
        busy      <= 1'b1;
        operation <= OP_LDST;
    end else if (move_done || ldst_done) begin
        busy <= 1'b0;
    end
end

// RAM port goes to the engine that owns the current operation
always_comb begin
    case (operation)
        OP_MV: begin
            rf_addr = mv_addr;
            rf_d    = mv_d;
            rf_we   = mv_we;
            rf_re   = mv_re;
        end
        default: begin
            rf_addr = ldst_addr;
            rf_d    = ldst_d;
            rf_we   = ldst_we;
            rf_re   = ldst_re;
        end
    endcase
end

rf_ram #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
) i_rf_ram (
    .clk  (clk),
    .addr (rf_addr),
    .d    (rf_d),
    .we   (rf_we),
    .re   (rf_re),
    .q    (rf_q)
);

rf_mv #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
) i_rf_mv (
    .clk      (clk),
    .rst      (rst),
    .start    (mv_go),
    .src_addr (move_src_addr),
    .dst_addr (move_dst_addr),
    .line_num (move_line_num),
    .ram_addr (mv_addr),
    .ram_d    (mv_d),
    .ram_we   (mv_we),
    .ram_re   (mv_re),
    .ram_q    (rf_q),
    .done     (move_done)
);

rf_ldst #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .SDRAM_ADDR_W (SDRAM_ADDR_W),
    .SDRAM_DATA_W (SDRAM_DATA_W)
) i_rf_ldst (
    .clk               (clk),
    .rst               (rst),
    .load_start        (ld_go),
    .store_start       (st_go),
    .rf_addr_base      (ldst_rf_addr),
    .sdram_addr_base   (ldst_sdram_addr),
    .line_num          (ldst_line_num),
    .ram_addr          (ldst_addr),
    .ram_d             (ldst_d),
    .ram_we            (ldst_we),
    .ram_re            (ldst_re),
    .ram_q             (rf_q),
    .avs_address       (avs_address),
    .avs_read          (avs_read),
    .avs_write         (avs_write),
    .avs_writedata     (avs_writedata),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_waitrequest   (avs_waitrequest),
    .done              (ldst_done)
);

endmodule

// File: sim/rf_checker.sv
`timescale 1ns/1ns

module rf_checker
    import rf_pkg::*;
    import sdram_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      move_start,
    input  logic [RF_ADDR_W-1 : 0]    move_src_addr,
    input  logic [RF_ADDR_W-1 : 0]    move_dst_addr,
    input  logic [LINE_CNT_W-1 : 0]   move_line_num,
    input  logic                      move_done,
    input  logic                      load_start,
    input  logic                      store_start,
    input  logic [RF_ADDR_W-1 : 0]    ldst_rf_addr,
    input  logic [SDRAM_ADDR_W-1 : 0] ldst_sdram_addr,
    input  logic [LINE_CNT_W-1 : 0]   ldst_line_num,
    input  logic                      ldst_done,
    input  logic                      busy,
    input  logic [SDRAM_ADDR_W-1 : 0] avs_address,
    input  logic                      avs_read,
    input  logic                      avs_write,
    input  logic [SDRAM_DATA_W-1 : 0] avs_writedata,
    input  logic                      avs_waitrequest,
    input  int                        exp_move_cycles,
    output int                        errors,
    output int                        cmds_done,
    output int                        cmds_passed,
    output int                        cmds_failed
);

logic [RF_DATA_W-1 : 0]    model_rf [1 << RF_ADDR_W];
logic [SDRAM_DATA_W-1 : 0] model_sd [4096];
logic [31:0]               exp_addr_q [$];
logic [SDRAM_DATA_W-1 : 0] exp_data_q [$];
logic [31:0]               exp_rd_q [$];
logic [31:0]               lcg_state;

bit  busy_exp;
bit  in_cmd;
byte cur_op;
int  cur_lines;
int  cur_exp_cycles;
int  start_cyc;
int  cyc;
int  cmd_errs;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    lcg_state   = 32'hd1fd;
    errors      = 0;
    cmds_done   = 0;
    cmds_passed = 0;
    cmds_failed = 0;
    cyc         = 0;
    for (int i = 0; i < 4096; i++) begin
        hi = lcg_next();
        lo = lcg_next();
        model_sd[i] = {hi, lo} ^ 64'(i);
    end
    for (int i = 0; i < (1 << RF_ADDR_W); i++) begin
        model_rf[i] = '0;
    end
end

task automatic value_error(input string what, input logic [63:0] exp, input logic [63:0] got);
    $display("** Error (%0t ns): %s expected %h got %h", $time, what, exp, got);
    errors++;
    cmd_errs++;
endtask

task automatic plain_error(input string what);
    $display("Checker: %s at %0t ns", what, $time);
    errors++;
    cmd_errs++;
endtask

// Effect of each accepted command on the models
task automatic begin_command(input byte op);
    logic [RF_ADDR_W-1 : 0] s;
    logic [RF_ADDR_W-1 : 0] d;
    logic [11:0]            a;
    in_cmd         = 1'b1;
    cur_op         = op;
    cmd_errs       = 0;
    start_cyc      = cyc;
    cur_exp_cycles = exp_move_cycles;
    if (op == "M") begin
        cur_lines = int'(move_line_num);
        // Ascending copy one line after another
        for (int i = 0; i < cur_lines; i++) begin
            s = move_src_addr + RF_ADDR_W'(i);
            d = move_dst_addr + RF_ADDR_W'(i);
            model_rf[d] = model_rf[s];
        end
    end else begin
        cur_lines = int'(ldst_line_num);
        for (int i = 0; i < cur_lines; i++) begin
            d = ldst_rf_addr + RF_ADDR_W'(i);
            for (int j = 0; j < BEATS_PER_LINE; j++) begin
                a = ldst_sdram_addr[11:0] + 12'(4 * i + j);
                if (op == "L") begin
                    exp_rd_q.push_back(ldst_sdram_addr + 32'(4 * i + j));
                    model_rf[d][64*j +: 64] = model_sd[a];
                end else begin
                    exp_addr_q.push_back(ldst_sdram_addr + 32'(4 * i + j));
                    exp_data_q.push_back(model_rf[d][64*j +: 64]);
                    model_sd[a] = model_rf[d][64*j +: 64];
                end
            end
        end
    end
endtask

task automatic end_command();
    $display("Command %0d (%c, %0d lines): %s", cmds_done, cur_op, cur_lines,
             (cmd_errs == 0) ? "ok" : "FAILED");
    cmds_done++;
    if (cmd_errs == 0) begin
        cmds_passed++;
    end else begin
        cmds_failed++;
    end
    in_cmd = 1'b0;
endtask

always @(posedge clk) begin
    bit accepted;
    bit finished;
    logic [31:0] ea;
    logic [63:0] ed;
    logic [31:0] ra;
    accepted = 1'b0;
    finished = 1'b0;
    if (rst) begin
        busy_exp = 1'b0;
        in_cmd   = 1'b0;
    end else begin
        cyc++;
        if (busy !== busy_exp) begin
            value_error("busy", 64'(busy_exp), 64'(busy));
        end
        // Starts count only while idle
        if (!busy_exp) begin
            if (move_start) begin
                begin_command("M");
                accepted = 1'b1;
            end else if (load_start) begin
                begin_command("L");
                accepted = 1'b1;
            end else if (store_start) begin
                begin_command("S");
                accepted = 1'b1;
            end
        end
        if (avs_read && !avs_waitrequest) begin
            if (exp_rd_q.size() == 0) begin
                plain_error("SDRAM read with no load beat pending");
            end else begin
                ra = exp_rd_q.pop_front();
                if (avs_address !== ra) begin
                    value_error("load address", 64'(ra), 64'(avs_address));
                end
            end
        end
        if (avs_write && !avs_waitrequest) begin
            if (exp_addr_q.size() == 0) begin
                plain_error("SDRAM write with no store beat pending");
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                if (avs_address !== ea) begin
                    value_error("store address", 64'(ea), 64'(avs_address));
                end
                if (avs_writedata !== ed) begin
                    value_error("store data", ed, avs_writedata);
                end
            end
        end
        if (move_done) begin
            if (!in_cmd || cur_op != "M") begin
                plain_error("move_done pulsed with no move running");
            end else begin
                if (cur_exp_cycles != 0 && cyc - start_cyc != cur_exp_cycles) begin
                    value_error("move cycles", 64'(cur_exp_cycles), 64'(cyc - start_cyc));
                end
                end_command();
                finished = 1'b1;
            end
        end
        if (ldst_done) begin
            if (!in_cmd || cur_op == "M") begin
                plain_error("ldst_done pulsed with no load or store running");
            end else begin
                if (exp_rd_q.size() != 0) begin
                    plain_error("load ended before all beats were read");
                    exp_rd_q.delete();
                end
                if (exp_addr_q.size() != 0) begin
                    plain_error("store ended before all beats were written");
                    exp_addr_q.delete();
                    exp_data_q.delete();
                end
                end_command();
                finished = 1'b1;
            end
        end
        if (accepted) begin
            busy_exp = 1'b1;
        end else if (finished) begin
            busy_exp = 1'b0;
        end
    end
end

endmodule

// File: sim/register_file_props.sv
`timescale 1ns/1ns

module register_file_props
    import sdram_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic [SDRAM_ADDR_W-1 : 0] avs_address,
    input logic                      avs_read,
    input logic                      avs_write,
    input logic [SDRAM_DATA_W-1 : 0] avs_writedata,
    input logic                      avs_waitrequest,
    input logic                      move_done,
    input logic                      ldst_done,
    input logic                      busy
);

a_one_direction: assert property (@(posedge clk) disable iff (rst)
    !(avs_read && avs_write))
    else $error("avs_read and avs_write high together");

// Stalled requests hold still
a_read_held: assert property (@(posedge clk) disable iff (rst)
    avs_read && avs_waitrequest |=> avs_read && $stable(avs_address))
    else $error("read request changed under waitrequest");

a_write_held: assert property (@(posedge clk) disable iff (rst)
    avs_write && avs_waitrequest |=>
        avs_write && $stable(avs_address) && $stable(avs_writedata))
    else $error("write request changed under waitrequest");

a_move_pulse: assert property (@(posedge clk) disable iff (rst)
    move_done |=> !move_done)
    else $error("move_done longer than one cycle");

a_ldst_pulse: assert property (@(posedge clk) disable iff (rst)
    ldst_done |=> !ldst_done)
    else $error("ldst_done longer than one cycle");

a_idle_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !busy)
    else $error("busy high right after reset");

endmodule

bind register_file register_file_props props_i (
    .clk             (clk),
    .rst             (rst),
    .avs_address     (avs_address),
    .avs_read        (avs_read),
    .avs_write       (avs_write),
    .avs_writedata   (avs_writedata),
    .avs_waitrequest (avs_waitrequest),
    .move_done       (move_done),
    .ldst_done       (ldst_done),
    .busy            (busy)
);

// File: sim/tb_register_file.sv
`timescale 1ns/1ns

module tb_register_file
    import rf_pkg::*;
    import sdram_pkg::*;
();

localparam int MAX_CMDS = 64;
localparam int SD_WORDS = 4096;

logic                      clk;
logic                      rst;
logic                      move_start;
logic [RF_ADDR_W-1 : 0]    move_src_addr;
logic [RF_ADDR_W-1 : 0]    move_dst_addr;
logic [LINE_CNT_W-1 : 0]   move_line_num;
logic                      move_done;
logic                      load_start;
logic                      store_start;
logic [RF_ADDR_W-1 : 0]    ldst_rf_addr;
logic [SDRAM_ADDR_W-1 : 0] ldst_sdram_addr;
logic [LINE_CNT_W-1 : 0]   ldst_line_num;
logic                      ldst_done;
logic                      busy;
logic [SDRAM_ADDR_W-1 : 0] avs_address;
logic                      avs_read;
logic                      avs_write;
logic [SDRAM_DATA_W-1 : 0] avs_writedata;
logic [SDRAM_DATA_W-1 : 0] avs_readdata;
logic                      avs_readdatavalid;
logic                      avs_waitrequest;

int exp_move_cycles;
int errors;
int cmds_done;
int cmds_passed;
int cmds_failed;

// Command table filled from the tests file
byte         cmd_op   [MAX_CMDS];
logic [31:0] cmd_a    [MAX_CMDS];
logic [31:0] cmd_b    [MAX_CMDS];
int          cmd_n    [MAX_CMDS];
int          cmd_poke [MAX_CMDS];
int          cmd_lat  [MAX_CMDS];
int          num_cmds;
int          total_lines;
bit          file_ok;

// SDRAM slave model
logic [SDRAM_DATA_W-1 : 0] sd_mem [SD_WORDS];
logic [SDRAM_DATA_W-1 : 0] rd_data_q [$];
int                        rd_due_q [$];
int                        edge_cnt = 0;
logic [31:0]               lcg_state;

register_file uut (
    .clk               (clk),
    .rst               (rst),
    .move_start        (move_start),
    .move_src_addr     (move_src_addr),
    .move_dst_addr     (move_dst_addr),
    .move_line_num     (move_line_num),
    .move_done         (move_done),
    .load_start        (load_start),
    .store_start       (store_start),
    .ldst_rf_addr      (ldst_rf_addr),
    .ldst_sdram_addr   (ldst_sdram_addr),
    .ldst_line_num     (ldst_line_num),
    .ldst_done         (ldst_done),
    .busy              (busy),
    .avs_address       (avs_address),
    .avs_read          (avs_read),
    .avs_write         (avs_write),
    .avs_writedata     (avs_writedata),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_waitrequest   (avs_waitrequest)
);

rf_checker chk (
    .clk               (clk),
    .rst               (rst),
    .move_start        (move_start),
    .move_src_addr     (move_src_addr),
    .move_dst_addr     (move_dst_addr),
    .move_line_num     (move_line_num),
    .move_done         (move_done),
    .load_start        (load_start),
    .store_start       (store_start),
    .ldst_rf_addr      (ldst_rf_addr),
    .ldst_sdram_addr   (ldst_sdram_addr),
    .ldst_line_num     (ldst_line_num),
    .ldst_done         (ldst_done),
    .busy              (busy),
    .avs_address       (avs_address),
    .avs_read          (avs_read),
    .avs_write         (avs_write),
    .avs_writedata     (avs_writedata),
    .avs_waitrequest   (avs_waitrequest),
    .exp_move_cycles   (exp_move_cycles),
    .errors            (errors),
    .cmds_done         (cmds_done),
    .cmds_passed       (cmds_passed),
    .cmds_failed       (cmds_failed)
);

always #4 clk = ~clk;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Preload with the same image as the checker builds
initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    lcg_state = 32'hd1fd;
    for (int i = 0; i < SD_WORDS; i++) begin
        hi = lcg_next();
        lo = lcg_next();
        sd_mem[i] = {hi, lo} ^ 64'(i);
    end
end

// Accepted requests with read data due two cycles later
always @(posedge clk) begin
    if (avs_write && !avs_waitrequest) begin
        sd_mem[avs_address[11:0]] = avs_writedata;
    end
    if (avs_read && !avs_waitrequest) begin
        rd_data_q.push_back(sd_mem[avs_address[11:0]]);
        rd_due_q.push_back(edge_cnt + 2);
    end
    edge_cnt <= edge_cnt + 1;
end

// Slave outputs change mid-cycle and stall about one cycle in three
always @(negedge clk) begin
    avs_waitrequest = ((lcg_next() >> 16) % 32'd3) == 32'd0;
    if (rd_due_q.size() > 0 && rd_due_q[0] == edge_cnt) begin
        avs_readdatavalid = 1'b1;
        avs_readdata      = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
    end else begin
        avs_readdatavalid = 1'b0;
        avs_readdata      = '0;
    end
end

task automatic read_tests();
    int    fd;
    int    code;
    string line;
    byte   op;
    logic [31:0] a;
    logic [31:0] b;
    int    n;
    int    poke;
    int    lat;
    num_cmds    = 0;
    total_lines = 0;
    fd = $fopen("sim/register_file_tests.txt", "r");
    file_ok = (fd != 0);
    if (file_ok) begin
        while (!$feof(fd) && num_cmds < MAX_CMDS) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%c %h %h %d %d %d", op, a, b, n, poke, lat) == 6) begin
                    cmd_op[num_cmds]   = op;
                    cmd_a[num_cmds]    = a;
                    cmd_b[num_cmds]    = b;
                    cmd_n[num_cmds]    = n;
                    cmd_poke[num_cmds] = poke;
                    cmd_lat[num_cmds]  = lat;
                    total_lines += n;
                    num_cmds++;
                end
            end
        end
        $fclose(fd);
    end
endtask

task automatic watchdog(input int limit);
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
endtask

task automatic wait_for_done(input bit is_move);
    @(negedge clk);
    while (is_move ? !move_done : !ldst_done) begin
        @(negedge clk);
    end
    @(negedge clk);
    while (busy) begin
        @(negedge clk);
    end
endtask

task automatic run_command(input int k);
    @(negedge clk);
    exp_move_cycles = cmd_lat[k];
    case (cmd_op[k])
        "M": begin
            move_src_addr = RF_ADDR_W'(cmd_a[k]);
            move_dst_addr = RF_ADDR_W'(cmd_b[k]);
            move_line_num = LINE_CNT_W'(cmd_n[k]);
            move_start    = 1'b1;
        end
        "L": begin
            ldst_rf_addr    = RF_ADDR_W'(cmd_a[k]);
            ldst_sdram_addr = cmd_b[k];
            ldst_line_num   = LINE_CNT_W'(cmd_n[k]);
            load_start      = 1'b1;
        end
        default: begin
            ldst_rf_addr    = RF_ADDR_W'(cmd_a[k]);
            ldst_sdram_addr = cmd_b[k];
            ldst_line_num   = LINE_CNT_W'(cmd_n[k]);
            store_start     = 1'b1;
        end
    endcase
    @(negedge clk);
    move_start  = 1'b0;
    load_start  = 1'b0;
    store_start = 1'b0;
    // Stray start of the other engine while busy
    if (cmd_poke[k] != 0) begin
        @(negedge clk);
        if (cmd_op[k] == "M") begin
            load_start = 1'b1;
        end else begin
            move_start = 1'b1;
        end
        @(negedge clk);
        load_start = 1'b0;
        move_start = 1'b0;
    end
    wait_for_done(cmd_op[k] == "M");
endtask

initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    move_start        = 1'b0;
    move_src_addr     = '0;
    move_dst_addr     = '0;
    move_line_num     = '0;
    load_start        = 1'b0;
    store_start       = 1'b0;
    ldst_rf_addr      = '0;
    ldst_sdram_addr   = '0;
    ldst_line_num     = '0;
    avs_readdata      = '0;
    avs_readdatavalid = 1'b0;
    avs_waitrequest   = 1'b0;
    exp_move_cycles   = 0;
    read_tests();
    if (!file_ok) begin
        $display("Could not open sim/register_file_tests.txt");
        $display("Simulation failed");
        $finish;
    end else begin
        fork
            watchdog(total_lines * 40 + 200);
        join_none
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < num_cmds; k++) begin
            run_command(k);
        end
        repeat (4) @(negedge clk);
        $display("Commands: %0d of %0d finished, %0d passed, %0d failed, %0d errors",
                 cmds_done, num_cmds, cmds_passed, cmds_failed, errors);
        if (errors == 0 && cmds_failed == 0 && cmds_done == num_cmds) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
end

endmodule

// File: sim/register_file_tests.txt
# op a b lines poke move_cycles (a, b in hex; lines, poke, cycles in decimal)
# L/S: a = rf line, b = sdram word; M: a = src, b = dst; poke 1 = stray start while busy
L 10 0000 4 0 0
S 10 0800 4 0 0
L 40 0100 6 0 0
M 40 80 6 1 13
S 80 0900 6 0 0
L 20 0200 12 0 0
M 24 20 8 0 17
S 20 0a00 12 0 0
L c0 0300 3 1 0
S c0 0b00 3 1 0
M c0 c8 1 0 3
S c8 0c00 1 0 0

// File: src.f
hw/rf_pkg.sv
hw/sdram_pkg.sv
hw/rf_ram.sv
hw/rf_mv.sv
hw/rf_ldst.sv
hw/register_file.sv
sim/rf_checker.sv
sim/register_file_props.sv
sim/tb_register_file.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_register_file
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
